// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_snd_board
FLIST = snd_board.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: snd_board.f
source/snd_pkg.sv
source/snd_frac_cen.sv
source/snd_cmd_seq.sv
source/snd_tone.sv
source/snd_dcrm_mix.sv
source/snd_board.sv
tb/tb_clk_gen.sv
tb/tb_snd_checker.sv
tb/tb_snd_board.sv

// File: source/snd_board.sv
// Sound board without CPU. Commands run fixed ROM lists and the right channel copies the left
`timescale 1ns/1ps

module snd_board import snd_pkg::*; #(
    parameter logic [9:0] cen_n    = 10'd1,
    parameter logic [9:0] cen_m    = 10'd16,
    parameter int         dcrm_sw  = 8,
    parameter int         mix_gain = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      snd_irq,
    input  cmd_t      snd_latch,
    input  rom_data_t rom_data,
    input  logic      rom_ok,
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    output sample_t   snd_left,
    output sample_t   snd_right,
    output logic      sample
);

    logic      tick;
    logic      wr_en;
    rom_data_t wr_reg;
    rom_data_t wr_val;
    tone_sum_t tone_sum;

    assign sample    = tick;     // Same strobe that loads snd_left
    assign snd_right = snd_left; // Mono

    snd_frac_cen #(.cen_n(cen_n), .cen_m(cen_m)) u_cen (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .tick     ( tick      )
    );

    snd_cmd_seq u_seq (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .snd_irq  ( snd_irq   ),
        .snd_latch( snd_latch ),
        .rom_data ( rom_data  ),
        .rom_ok   ( rom_ok    ),
        .rom_addr ( rom_addr  ),
        .rom_cs   ( rom_cs    ),
        .wr_en    ( wr_en     ),
        .wr_reg   ( wr_reg    ),
        .wr_val   ( wr_val    )
    );

    snd_tone u_tone (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .tick     ( tick      ),
        .wr_en    ( wr_en     ),
        .wr_reg   ( wr_reg    ),
        .wr_val   ( wr_val    ),
        .tone_sum ( tone_sum  )
    );

    snd_dcrm_mix #(.dcrm_sw(dcrm_sw), .mix_gain(mix_gain)) u_mix (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .tick     ( tick      ),
        .tone_sum ( tone_sum  ),
        .snd_left ( snd_left  )
    );

endmodule

// File: source/snd_cmd_seq.sv
// Only the latest command byte is kept. A list has at most four records and lives at command*8
`timescale 1ns/1ps

module snd_cmd_seq import snd_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      snd_irq,
    input  cmd_t      snd_latch,
    input  rom_data_t rom_data,
    input  logic      rom_ok,
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    output logic      wr_en,
    output rom_data_t wr_reg,
    output rom_data_t wr_val
);

    logic       irq_d;      // Previous strobe level
    logic       irq_rise;
    logic       irq_flag;   // Pending interrupt
    logic       ack;        // Sequencer takes the pending command
    cmd_t       cmd;        // Latched byte, may be overwritten at any time
    cmd_t       list_cmd;   // Byte of the list being walked
    logic [1:0] rec_cnt;    // Record index inside the list
    seq_state_e state;

    assign irq_rise = snd_irq & ~irq_d;
    assign ack      = (state == idle) && irq_flag;
    assign rom_cs   = (state == fetch_reg) || (state == fetch_val);
    // Record n sits at byte 2n of the list, value byte right after
    assign rom_addr = rom_addr_t'({list_cmd, rec_cnt, state == fetch_val});

    // Edge triggered flop with clear on ack
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_d    <= 1'b0;
            irq_flag <= 1'b0;
        end else begin
            irq_d <= snd_irq;
            if (irq_rise) begin
                irq_flag <= 1'b1;   // New edge wins over the ack
            end else if (ack) begin
                irq_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (irq_rise) begin
            cmd <= snd_latch;
        end
        if (ack) begin
            list_cmd <= cmd;    // Frozen for the whole list
        end
        if (state == fetch_reg && rom_ok) begin
            wr_reg <= rom_data;
        end
        if (state == fetch_val && rom_ok) begin
            wr_val <= rom_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            wr_en   <= 1'b0;
            rec_cnt <= '0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                idle: begin
                    if (irq_flag) begin
                        state   <= fetch_reg;
                        rec_cnt <= '0;
                    end
                end
                fetch_reg: begin
                    if (rom_ok) begin
                        state <= (rom_data == reg_end) ? idle : fetch_val; // No value after end
                    end
                end
                fetch_val: begin
                    if (rom_ok) begin
                        state <= write;
                        wr_en <= 1'b1;  // Single clock write strobe
                    end
                end
                write: begin
                    if (rec_cnt == 2'(max_records - 1)) begin
                        state <= idle;  // List full
                    end else begin
                        state   <= fetch_reg;
                        rec_cnt <= rec_cnt + 2'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ROM may stall any number of cycles
    a_addr_hold: assert property (
        @(posedge clk) disable iff (rst) rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)
    ) else $error("rom_addr moved while waiting for rom_ok");

    a_wr_state: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> state == write
    ) else $error("wr_en outside write state");

endmodule

// File: source/snd_dcrm_mix.sv
// DC removal on tick, then fixed gain with 16 bit saturation. Settling takes ~2^dcrm_sw ticks
`timescale 1ns/1ps

module snd_dcrm_mix import snd_pkg::*; #(
    parameter int dcrm_sw  = 8,
    parameter int mix_gain = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      tick,
    input  tone_sum_t tone_sum,
    output sample_t   snd_left
);

    localparam int aw = $bits(tone_sum_t) + dcrm_sw; // Estimate with fraction bits
    localparam int pw = aw + 18;                      // Room for the product
    localparam logic signed [pw-1:0] gain_s = pw'(mix_gain);
    localparam logic signed [pw-1:0] smax   = pw'(32767);
    localparam logic signed [pw-1:0] smin   = pw'(-32768);

    logic        [aw-1:0] est;      // DC estimate, unsigned
    logic signed [aw:0]   diff;     // Input minus estimate
    logic signed [aw:0]   est_nxt;
    logic signed [pw-1:0] prod;
    logic signed [pw-1:0] scaled;
    sample_t              sat;

    always_comb begin
        diff    = $signed({1'b0, tone_sum, {dcrm_sw{1'b0}}}) - $signed({1'b0, est});
        est_nxt = $signed({1'b0, est}) + (diff >>> dcrm_sw); // Leaky follower
        prod    = pw'(diff) * gain_s;
        scaled  = prod >>> dcrm_sw;     // Back to integer units
        if (scaled > smax) begin
            sat = 16'sh7fff;
        end else if (scaled < smin) begin
            sat = -16'sh8000;
        end else begin
            sat = sample_t'(scaled);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            est      <= '0;
            snd_left <= '0;
        end else if (tick) begin
            est      <= est_nxt[aw-1:0];  // Stays between 0 and the input
            snd_left <= sat;
        end
    end

    // Next estimate must fit the unsigned register it is truncated into
    a_est_range: assert property (
        @(posedge clk) disable iff (rst) tick |-> !est_nxt[aw]
    ) else $error("DC estimate left its unsigned range");

endmodule

// File: source/snd_frac_cen.sv
// Gives cen_n pulses every cen_m clocks. Needs cen_n at most cen_m/2 so pulses never touch
`timescale 1ns/1ps

module snd_frac_cen #(
    parameter logic [9:0] cen_n = 10'd1,
    parameter logic [9:0] cen_m = 10'd16
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [9:0]  acc;   // Remainder, always below cen_m
    logic [10:0] sum;   // One extra bit so acc plus cen_n cannot wrap

    always_comb begin
        sum = {1'b0, acc} + {1'b0, cen_n};
    end

    // Bresenham style stepping, no drift over time
    always_ff @(posedge clk) begin
        if (rst) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (sum >= {1'b0, cen_m}) begin
            acc  <= 10'(sum - {1'b0, cen_m}); // Wrap and fire
            tick <= 1'b1;
        end else begin
            acc  <= sum[9:0];
            tick <= 1'b0;
        end
    end

    // Downstream logic treats tick as a strobe, one clock wide
    a_tick_single: assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    ) else $error("tick high on two consecutive clocks");

endmodule

// File: source/snd_pkg.sv
// Shared types and constants for the sound board. The register map covers three tone channels only
package snd_pkg;

    typedef logic [7:0]         cmd_t;      // Command byte from main controller
    typedef logic [14:0]        rom_addr_t; // ROM byte address
    typedef logic [7:0]         rom_data_t; // ROM byte
    typedef logic [7:0]         period_t;   // Half period in ticks, minus one
    typedef logic [3:0]         vol_t;      // Channel volume
    typedef logic [5:0]         tone_sum_t; // Unipolar sum of three volumes
    typedef logic signed [15:0] sample_t;   // Audio output

    // Command list walker
    typedef enum logic [1:0] {
        idle,
        fetch_reg,
        fetch_val,
        write
    } seq_state_e;

    localparam rom_data_t reg_end     = 8'hff; // Early end of a list
    localparam int        max_records = 4;     // Writes per command at most

    // Register map
    localparam rom_data_t reg_per0 = 8'h00;  // Periods at 0..2
    localparam rom_data_t reg_vol0 = 8'h04;  // Volumes at 4..6, low nibble
    localparam int        num_ch   = 3;

endpackage

// File: source/snd_tone.sv
// Three square channels paced by tick. Registers 3 and 7 and above are ignored
`timescale 1ns/1ps

module snd_tone import snd_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      tick,
    input  logic      wr_en,
    input  rom_data_t wr_reg,
    input  rom_data_t wr_val,
    output tone_sum_t tone_sum
);

    period_t              per [num_ch];  // Half periods
    vol_t                 vol [num_ch];
    period_t              cnt [num_ch];  // Down counters
    logic    [num_ch-1:0] lvl;           // Square levels
    logic    [num_ch-1:0] lvl_nxt;       // Levels after this tick
    tone_sum_t            sum_nxt;

    // Toggle when the counter has run out
    always_comb begin
        sum_nxt = '0;
        for (int i = 0; i < num_ch; i++) begin
            lvl_nxt[i] = lvl[i] ^ (cnt[i] == '0);
            if (lvl_nxt[i]) begin
                sum_nxt = sum_nxt + tone_sum_t'(vol[i]);
            end
        end
    end

    // Register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_ch; i++) begin
                per[i] <= '0;
                vol[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < num_ch; i++) begin
                if (wr_reg == reg_per0 + rom_data_t'(i)) begin
                    per[i] <= wr_val;
                end
                if (wr_reg == reg_vol0 + rom_data_t'(i)) begin
                    vol[i] <= wr_val[3:0];  // High nibble dropped
                end
            end
        end
    end

    // Generators
    always_ff @(posedge clk) begin
        if (rst) begin
            lvl      <= '0;
            tone_sum <= '0;
            for (int i = 0; i < num_ch; i++) begin
                cnt[i] <= '0;
            end
        end else if (tick) begin
            lvl      <= lvl_nxt;
            tone_sum <= sum_nxt;    // PSG style, only high channels add
            for (int i = 0; i < num_ch; i++) begin
                cnt[i] <= (cnt[i] == '0) ? per[i] : cnt[i] - 8'd1; // Reload gives per+1 ticks
            end
        end
    end

endmodule

// File: tb/tb_clk_gen.sv
// 20 ns clock, reset high for the first 8 rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;     // Released away from the sampling edge
    end

endmodule

// File: tb/tb_snd_board.sv
// Board run with default parameters. ROM lists exist for commands 1 to 5 only
`timescale 1ns/1ps

module tb_snd_board import snd_pkg::*; ;

    localparam logic [9:0] cen_n     = 10'd1;
    localparam logic [9:0] cen_m     = 10'd16;
    localparam int         mix_gain  = 64;
    localparam period_t    per_skip  = 8'hff;    // No tone check for this row
    localparam period_t    per_quiet = 8'hfe;    // Expect silence

    typedef struct packed {
        cmd_t        cmd;
        logic [31:0] gap;   // Clocks after the list ends, or before the next edge
        logic [2:0]  recs;
        period_t     per;
        logic        b2b;   // Next command arrives while this list runs
    } row_t;

    logic       clk;
    logic       rst;
    logic       snd_irq   = 1'b0;
    cmd_t       snd_latch = '0;
    rom_data_t  rom_data  = '0;
    logic       rom_ok    = 1'b0;
    rom_addr_t  rom_addr;
    logic       rom_cs;
    sample_t    snd_left;
    sample_t    snd_right;
    logic       sample;
    logic       req       = 1'b0;
    logic [1:0] req_kind  = '0;
    cmd_t       req_cmd   = '0;
    logic [2:0] req_recs  = '0;
    period_t    req_per   = '0;
    logic       req_last  = 1'b0;
    int         req_id    = 0;
    int         errors;
    int         tests;
    bit         timed_out;
    int         rom_delay;
    int         seed_draw;
    int         wait_n;
    logic       rom_armed;
    logic [1:0] kind;
    logic [7:0] rom [0:32767];
    row_t       tbl [0:4];
    int         pending[$];

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    snd_board #(.cen_n(cen_n), .cen_m(cen_m), .mix_gain(mix_gain)) i_dut (
        .clk(clk), .rst(rst), .snd_irq(snd_irq), .snd_latch(snd_latch),
        .rom_data(rom_data), .rom_ok(rom_ok), .rom_addr(rom_addr), .rom_cs(rom_cs),
        .snd_left(snd_left), .snd_right(snd_right), .sample(sample)
    );

    tb_snd_checker #(.cen_n(cen_n), .cen_m(cen_m), .mix_gain(mix_gain)) u_chk (
        .clk(clk), .rst(rst), .snd_irq(snd_irq), .rom_addr(rom_addr), .rom_cs(rom_cs),
        .rom_ok(rom_ok), .snd_left(snd_left), .snd_right(snd_right), .sample(sample),
        .req(req), .req_kind(req_kind), .req_cmd(req_cmd), .req_recs(req_recs),
        .req_per(req_per), .req_last(req_last), .req_id(req_id),
        .errors(errors), .tests(tests)
    );

    // ROM answers each read after 0 to 5 clocks
    always @(negedge clk) begin
        if (rst || !rom_cs) begin
            rom_ok    = 1'b0;
            rom_armed = 1'b0;
        end else if (!rom_armed || rom_ok) begin   // New read, or last one consumed
            rom_armed = 1'b1;
            rom_delay = int'($urandom % 6);
            rom_ok    = (rom_delay == 0);
        end else begin
            rom_delay--;
            rom_ok = (rom_delay == 0);
        end
        rom_data = rom[rom_addr];
    end

    task automatic put_list(cmd_t c, logic [63:0] bytes, int n);
        for (int k = 0; k < n; k++) rom[int'({c, 3'b000}) + k] = bytes[63 - 8*k -: 8];
    endtask

    task automatic wait_clocks(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drive_cmd(cmd_t c);
        snd_latch = c;
        snd_irq   = 1'b1;
        @(negedge clk);
        snd_irq   = 1'b0;
    endtask

    task automatic send_req(logic [1:0] k, int row, logic last);
        req      = 1'b1;
        req_kind = k;
        req_cmd  = tbl[row].cmd;
        req_recs = tbl[row].recs;
        req_per  = tbl[row].per;
        req_last = last;
        req_id   = row;
        @(negedge clk);
        req      = 1'b0;
    endtask

    // Busy once rom_cs rises, done after 16 quiet clocks
    task automatic wait_list_done();
        int n;
        int low;
        n = 0;
        while (!rom_cs && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!rom_cs) begin
            $display("Timeout: rom_cs never rose after a command");
            timed_out = 1'b1;
            return;
        end
        n   = 0;
        low = 0;
        while (low < 16 && n < 2000) begin
            @(negedge clk);
            low = rom_cs ? 0 : low + 1;
            n++;
        end
        if (low < 16) begin
            $display("Timeout: command list never finished");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed_draw = int'($urandom(32'h9c77_069f));
        timed_out = 1'b0;
        for (int a = 0; a < 32768; a++) rom[a] = 8'(a) ^ 8'(a >> 7);
        put_list(8'h01, 64'h0009_040f_0500_0600, 8);
        put_list(8'h02, 64'h0004_ff00_0000_0000, 3);
        put_list(8'h03, 64'h0400_0500_0600_ff00, 7);
        put_list(8'h04, 64'h0120_ff00_0000_0000, 3);
        put_list(8'h05, 64'h0230_0500_ff00_0000, 5);
        tbl[0] = '{8'h01, 32'd34000, 3'd4, 8'd9, 1'b0};
        tbl[1] = '{8'h02, 32'd34000, 3'd1, 8'd4, 1'b0};
        tbl[2] = '{8'h04, 32'd1, 3'd1, per_skip, 1'b1};
        tbl[3] = '{8'h05, 32'd200, 3'd2, per_skip, 1'b0};
        tbl[4] = '{8'h03, 32'd34000, 3'd3, per_quiet, 1'b0};

        wait_n = 0;
        while (rst !== 1'b0 && wait_n < 100) begin
            @(negedge clk);
            wait_n++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset never released");
            timed_out = 1'b1;
        end
        wait_clocks(40);   // Idle board before any command

        for (int i = 0; i < 5; i++) begin
            if (timed_out) break;
            kind = (tbl[i].per == per_quiet) ? 2'd2 : ((tbl[i].per == per_skip) ? 2'd0 : 2'd1);
            drive_cmd(tbl[i].cmd);
            if (tbl[i].b2b) begin
                pending.push_back(i);
                wait_clocks(int'(tbl[i].gap));
                continue;
            end
            wait_list_done();
            while (pending.size() > 0) send_req(2'd0, pending.pop_front(), 1'b1);
            send_req(2'd0, i, kind == 2'd0);
            wait_clocks(int'(tbl[i].gap));
            if (kind != 2'd0) send_req(kind, i, 1'b1);
        end
        wait_clocks(4);

        $display("tests %0d errors %0d timeout %0d", tests, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tb/tb_snd_checker.sv
// Expects at most one request per clock; list reads must be requested in the order they ran
`timescale 1ns/1ps

module tb_snd_checker import snd_pkg::*; #(
    parameter logic [9:0] cen_n    = 10'd1,
    parameter logic [9:0] cen_m    = 10'd16,
    parameter int         mix_gain = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      snd_irq,
    input  rom_addr_t rom_addr,
    input  logic      rom_cs,
    input  logic      rom_ok,
    input  sample_t   snd_left,
    input  sample_t   snd_right,
    input  logic      sample,
    input  logic      req,
    input  logic [1:0] req_kind,  // 0 list, 1 tone period, 2 silence
    input  cmd_t      req_cmd,
    input  logic [2:0] req_recs,
    input  period_t   req_per,
    input  logic      req_last,   // Request closes the test
    input  int        req_id,
    output int        errors,
    output int        tests
);

    rom_addr_t reads[$];        // Accepted ROM addresses in order
    logic      started;         // First command seen
    logic      irq_d;
    logic      wait_prev;       // Read was stalled last clock
    logic      idle_err_seen;
    logic      rst_done;        // DUT has run one clock since reset
    rom_addr_t addr_prev;
    sample_t   last_left;
    int        smp_cnt;
    int        last_cross;
    int        cross_gap;       // Samples between the last two rising crossings
    int        cross_cnt;
    int        win_clk;
    int        win_smp;
    int        test_errs;

    initial begin
        errors        = 0;
        tests         = 0;
        test_errs     = 0;
        idle_err_seen = 1'b0;
        last_left     = '0;
        last_cross    = 0;
        cross_gap     = 0;
        cross_cnt     = 0;
    end

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        errors++;
        test_errs++;
    endtask

    task automatic report_error(string what);
        $display("Error: %s", what);
        errors++;
        test_errs++;
    endtask

    // List rule: bytes from c*8 on, one extra read for the end marker if short
    task automatic check_list(cmd_t c, logic [2:0] recs);
        int        n;
        rom_addr_t exp;
        rom_addr_t got;
        n = 2 * int'(recs) + ((recs < 3'd4) ? 1 : 0);
        for (int k = 0; k < n; k++) begin
            exp = rom_addr_t'({c, 3'b000}) + rom_addr_t'(k);
            if (reads.size() == 0) begin
                report_error($sformatf("ROM read %0d of command %h never happened", k, c));
                return;
            end
            got = reads.pop_front();
            if (got != exp) report_mismatch("rom_addr", 32'(got), 32'(exp));
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            started   = 1'b0;
            irq_d     = 1'b0;
            wait_prev = 1'b0;
            rst_done  = 1'b0;
            smp_cnt   = 0;
            win_clk   = 0;
            win_smp   = 0;
        end else begin
            if (snd_irq && !irq_d) started = 1'b1;
            irq_d = snd_irq;
            // Quiet board until the first command
            if (!started && !idle_err_seen && (rom_cs || snd_left != '0)) begin
                idle_err_seen = 1'b1;
                if (rom_cs) report_mismatch("rom_cs", 32'(rom_cs), 32'h0);
                if (snd_left != '0) report_mismatch("snd_left", 32'(snd_left), 32'h0);
            end
            if (wait_prev && rom_addr != addr_prev) begin
                report_mismatch("rom_addr while stalled", 32'(rom_addr), 32'(addr_prev));
            end
            wait_prev = rom_cs && !rom_ok;
            addr_prev = rom_addr;
            if (rom_cs && rom_ok) reads.push_back(rom_addr);
            if (snd_right != snd_left) report_mismatch("snd_right", 32'(snd_right), 32'(snd_left));

            if (sample) smp_cnt++;
            if (last_left < 0 && snd_left >= 0) begin   // Rising zero crossing
                cross_gap  = smp_cnt - last_cross;
                last_cross = smp_cnt;
                cross_cnt++;
            end
            last_left = snd_left;

            // Fixed windows of 16*cen_m clocks; the first edge still sees the reset tick
            if (rst_done) begin
                win_smp = win_smp + int'(sample);
                if (win_clk == 16 * int'(cen_m) - 1) begin
                    if (win_smp != 16 * int'(cen_n)) begin
                        report_mismatch("sample count", 32'(win_smp), 32'(16 * int'(cen_n)));
                    end
                    win_clk = 0;
                    win_smp = 0;
                end else begin
                    win_clk++;
                end
            end
            rst_done = 1'b1;

            if (req) begin
                case (req_kind)
                    2'd0: check_list(req_cmd, req_recs);
                    2'd1: begin
                        if (cross_cnt < 2) begin
                            report_error("no steady zero crossings on snd_left");
                        end else if (cross_gap != 2 * (int'(req_per) + 1)) begin
                            report_mismatch("crossing spacing", 32'(cross_gap),
                                            32'(2 * (int'(req_per) + 1)));
                        end
                        cross_cnt = 0;
                    end
                    default: begin
                        if (snd_left >= mix_gain || snd_left <= -mix_gain) begin
                            report_mismatch("snd_left", 32'(snd_left), 32'h0);
                        end
                    end
                endcase
                if (req_last) begin
                    tests++;
                    $display("test %0d cmd %h: %s", req_id, req_cmd,
                             (test_errs == 0) ? "ok" : "failed");
                    test_errs = 0;
                end
            end
        end
    end

endmodule
